/* files.f */
irq_perturb_pkg.sv
irq_perturb_cfg.sv
irq_lane.sv
irq_arbiter.sv
irq_perturb_top.sv
tb_clock_gen.sv
tb_irq_perturb.sv

/* Makefile */
TOP := tb_irq_perturb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_irq_perturb.sv */
`timescale 1ns/1ps

module tb_irq_perturb;

    import irq_perturb_pkg::*;

    // Random lane window for the range test
    localparam int      RND_MIN_CYC = 3;
    localparam int      RND_MAX_CYC = 10;
    localparam int      RND_MIN_ID  = 4;
    localparam int      RND_MAX_ID  = 9;
    // PC trigger and priority setups
    localparam pc_t     PC_HIT      = 32'h0000_1f40;
    localparam irq_id_t PC_ID       = 5'd17;
    localparam pc_t     PRIO_PC     = 32'h0000_3a00;
    localparam irq_id_t PRIO_ID0    = 5'd3;
    localparam irq_id_t PRIO_ID3    = 5'd28;

    logic clk;
    logic rst_n;

    // DUT inputs
    logic      irq_i;
    irq_id_t   irq_id_i;
    logic      irq_ack;
    logic      byp_ack;
    logic      core_ack;
    pc_t       pc_i;
    logic      cfg_we;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_wdata;

    // DUT outputs
    logic      irq_o;
    irq_id_t   irq_id_o;
    logic      irq_ack_o;
    irq_id_t   irq_act_id_o;
    logic      irq_id_we_o;

    // Check enables and bookkeeping
    logic        test_bypass;
    logic        perturb_on;
    logic        chk_random;
    logic        chk_pc_arm;
    logic        chk_no_irq;
    logic        chk_prio;
    logic        pc_hit_q;
    logic        core_en;
    int          ack_extra;
    int          since_ref;
    int          prio_seen;
    int          we_count;
    irq_id_t     acked_id;
    logic [31:0] lfsr_state;
    string       test_name;
    int          errors;
    int          pass_count;
    int          fail_count;

    tb_clock_gen u_clk (.clk_o(clk), .rst_no(rst_n));

    // Core model owns the ack in perturb mode
    assign irq_ack = core_en ? core_ack : byp_ack;

    irq_perturb_top dut (
        .clk_i(clk), .rst_ni(rst_n), .irq_i, .irq_id_i, .irq_ack_i(irq_ack), .pc_i,
        .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
        .irq_o, .irq_id_o, .irq_ack_o, .irq_act_id_o, .irq_id_we_o
    );

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            v = (v << 1) | 32'(lfsr_state[31]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Land just after the edge where inputs are driven
    task automatic cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic value_fail(input string what, input string exp, input int unsigned act);
        errors++;
        $display("Fail %s: %s expected %s actual %0d", test_name, what, exp, act);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic write_cfg(input int lane, input field_t field, input cfg_data_t data);
        cfg_we    = 1'b1;
        cfg_addr  = {lane_idx_t'(lane), field};
        cfg_wdata = data;
        cycle();
        cfg_we    = 1'b0;
    endtask

    // Wait for ID report strobes counted from base
    task automatic wait_acks(input int base, input int count, input int limit);
        int k;
        k = 0;
        while (we_count - base < count && k < limit)
        begin
            cycle();
            k++;
        end
        if (we_count - base < count)
            report_error($sformatf("timed out with %0d of %0d interrupts acknowledged",
                                   we_count - base, count));
    endtask

    task automatic finish_test(input int start_errors);
        if (errors == start_errors)
        begin
            pass_count++;
            $display("test %s passed", test_name);
        end
        else
        begin
            fail_count++;
            $display("test %s failed with %0d errors", test_name, errors - start_errors);
        end
    endtask

    //////////////////////////////////////////////////
    // Core model
    //////////////////////////////////////////////////

    // Acks a pending irq after 0 to 7 cycles plus ack_extra
    initial
    begin
        int unsigned delay;
        forever
        begin
            cycle();
            if (core_en && irq_o)
            begin
                draw_bits(3, delay);
                delay = delay + ack_extra;
                repeat (delay) cycle();
                core_ack = 1'b1;
                cycle();
                core_ack = 1'b0;
            end
        end
    end

    // Cycles since rearm or since the end of cooldown
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            since_ref <= 0;
        else if (cfg_we)
            since_ref <= 0;
        else if (irq_o && irq_ack)
            since_ref <= -(RND_MAX_CYC + 1);
        else
            since_ref <= since_ref + 1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            acked_id  <= '0;
            pc_hit_q  <= 1'b0;
            prio_seen <= 0;
            we_count  <= 0;
        end
        else
        begin
            if (irq_o && irq_ack)
                acked_id <= irq_id_o;
            pc_hit_q <= chk_pc_arm && (pc_i == PC_HIT);
            if (chk_prio && irq_id_we_o)
                prio_seen <= prio_seen + 1;
            if (irq_id_we_o)
                we_count <= we_count + 1;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_bypass_pass : assert property (@(posedge clk) disable iff (!rst_n)
        test_bypass |-> ({irq_o, irq_id_o, irq_ack_o} == {irq_i, irq_id_i, irq_ack}))
        else value_fail("{irq, id, ack} out", $sformatf("%0d", $sampled({irq_i, irq_id_i,
            irq_ack})), $sampled({irq_o, irq_id_o, irq_ack_o}));

    a_bypass_we : assert property (@(posedge clk) disable iff (!rst_n)
        test_bypass |-> !irq_id_we_o)
        else value_fail("irq_id_we_o", "0", 1);

    // Rise lands between min+1 and max+2 cycles after the reference
    a_rnd_gap : assert property (@(posedge clk) disable iff (!rst_n)
        (chk_random && $rose(irq_o))
        |-> (since_ref >= RND_MIN_CYC + 1 && since_ref <= RND_MAX_CYC + 2))
        else value_fail("irq_o delay", $sformatf("%0d to %0d", RND_MIN_CYC + 1,
            RND_MAX_CYC + 2), $sampled(since_ref));

    a_rnd_id : assert property (@(posedge clk) disable iff (!rst_n)
        (chk_random && irq_o) |-> (irq_id_o >= RND_MIN_ID && irq_id_o <= RND_MAX_ID))
        else value_fail("irq_id_o", $sformatf("%0d to %0d", RND_MIN_ID, RND_MAX_ID),
            $sampled(irq_id_o));

    // Lane req follows the hit by one edge and irq_o by two
    a_pc_fire : assert property (@(posedge clk) disable iff (!rst_n)
        pc_hit_q |=> (irq_o && irq_id_o == PC_ID))
        else value_fail("{irq, id}", $sformatf("%0d", {1'b1, PC_ID}),
            $sampled({irq_o, irq_id_o}));

    a_pc_once : assert property (@(posedge clk) disable iff (!rst_n)
        chk_no_irq |-> !irq_o)
        else value_fail("irq_o", "0", 1);

    a_hold : assert property (@(posedge clk) disable iff (!rst_n)
        (perturb_on && irq_o && !irq_ack) |=> (irq_o && $stable(irq_id_o)))
        else report_error("irq_o or irq_id_o changed before the core acknowledged");

    a_we_after_ack : assert property (@(posedge clk) disable iff (!rst_n)
        (perturb_on && irq_o && irq_ack) |=> irq_id_we_o)
        else value_fail("irq_id_we_o", "1", 0);

    a_we_single : assert property (@(posedge clk) disable iff (!rst_n)
        (perturb_on && irq_id_we_o) |=> !irq_id_we_o)
        else value_fail("irq_id_we_o", "0", 1);

    a_we_cause : assert property (@(posedge clk) disable iff (!rst_n)
        (perturb_on && irq_id_we_o) |-> $past(irq_o && irq_ack))
        else report_error("irq_id_we_o pulsed with no acknowledge taken");

    a_act_id : assert property (@(posedge clk) disable iff (!rst_n)
        (perturb_on && irq_id_we_o) |-> (irq_act_id_o == acked_id))
        else value_fail("irq_act_id_o", $sformatf("%0d", $sampled(acked_id)),
            $sampled(irq_act_id_o));

    // Lane 0 delivered before lane 3
    a_prio_order : assert property (@(posedge clk) disable iff (!rst_n)
        (chk_prio && irq_id_we_o) |-> (irq_act_id_o == (prio_seen == 0 ? PRIO_ID0 : PRIO_ID3)))
        else value_fail("irq_act_id_o", $sformatf("%0d",
            $sampled(prio_seen) == 0 ? PRIO_ID0 : PRIO_ID3), $sampled(irq_act_id_o));

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic run_bypass();
        int          start;
        int unsigned v;
        test_name   = "bypass";
        start       = errors;
        test_bypass = 1'b1;
        repeat (40)
        begin
            draw_bits(1, v);
            irq_i = v[0];
            draw_bits(5, v);
            irq_id_i = irq_id_t'(v);
            draw_bits(1, v);
            byp_ack = v[0];
            cycle();
        end
        irq_i    = 1'b0;
        irq_id_i = '0;
        byp_ack  = 1'b0;
        cycle();
        test_bypass = 1'b0;
        finish_test(start);
    endtask

    task automatic run_random();
        int start;
        test_name = "random_range";
        start     = errors;
        write_cfg(1, FIELD_MIN_CYC, RND_MIN_CYC);
        write_cfg(1, FIELD_MAX_CYC, RND_MAX_CYC);
        write_cfg(1, FIELD_MIN_ID, RND_MIN_ID);
        write_cfg(1, FIELD_MAX_ID, RND_MAX_ID);
        chk_random = 1'b1;
        write_cfg(1, FIELD_MODE, LANE_RANDOM);
        wait_acks(we_count, 20, 1200);
        // Lane sits in cooldown here so switching it off loses no request
        chk_random = 1'b0;
        write_cfg(1, FIELD_MODE, LANE_OFF);
        finish_test(start);
    endtask

    // Walk pc_i across the hit address
    // A set arm marks the hit as an expected fire
    task automatic sweep_pc(input logic arm);
        pc_t a;
        a = PC_HIT - 16;
        while (a <= PC_HIT + 16)
        begin
            pc_i       = a;
            chk_pc_arm = arm && (a == PC_HIT);
            cycle();
            a = a + 4;
        end
        chk_pc_arm = 1'b0;
        pc_i       = 32'h0000_2000;
    endtask

    task automatic run_pc_trigger();
        int start;
        int base;
        test_name = "pc_trigger";
        start     = errors;
        write_cfg(2, FIELD_PC_TRIG, PC_HIT);
        write_cfg(2, FIELD_MIN_ID, PC_ID);
        write_cfg(2, FIELD_MODE, LANE_PC_TRIG);
        base = we_count;
        sweep_pc(1'b1);
        wait_acks(base, 1, 60);
        // Parked lane must stay silent on further hits
        chk_no_irq = 1'b1;
        sweep_pc(1'b0);
        sweep_pc(1'b0);
        repeat (5) cycle();
        chk_no_irq = 1'b0;
        write_cfg(2, FIELD_MODE, LANE_PC_TRIG);
        base = we_count;
        sweep_pc(1'b1);
        wait_acks(base, 1, 60);
        write_cfg(2, FIELD_MODE, LANE_OFF);
        finish_test(start);
    endtask

    task automatic run_hold();
        int start;
        test_name = "hold_until_ack";
        start     = errors;
        ack_extra = 4;
        write_cfg(0, FIELD_MIN_CYC, 2);
        write_cfg(0, FIELD_MAX_CYC, 5);
        write_cfg(0, FIELD_MIN_ID, 20);
        write_cfg(0, FIELD_MAX_ID, 30);
        write_cfg(0, FIELD_MODE, LANE_RANDOM);
        wait_acks(we_count, 10, 400);
        write_cfg(0, FIELD_MODE, LANE_OFF);
        ack_extra = 0;
        finish_test(start);
    endtask

    task automatic run_priority();
        int start;
        int base;
        test_name = "priority";
        start     = errors;
        write_cfg(0, FIELD_PC_TRIG, PRIO_PC);
        write_cfg(0, FIELD_MIN_ID, PRIO_ID0);
        write_cfg(3, FIELD_PC_TRIG, PRIO_PC);
        write_cfg(3, FIELD_MIN_ID, PRIO_ID3);
        write_cfg(0, FIELD_MODE, LANE_PC_TRIG);
        write_cfg(3, FIELD_MODE, LANE_PC_TRIG);
        // Both lanes hit on the same edge
        chk_prio = 1'b1;
        base     = we_count;
        pc_i     = PRIO_PC;
        cycle();
        pc_i = 32'h0000_2000;
        wait_acks(base, 2, 80);
        chk_prio = 1'b0;
        write_cfg(0, FIELD_MODE, LANE_OFF);
        write_cfg(3, FIELD_MODE, LANE_OFF);
        finish_test(start);
    endtask

    initial
    begin
        int k;
        irq_i       = 1'b0;
        irq_id_i    = '0;
        byp_ack     = 1'b0;
        core_ack    = 1'b0;
        pc_i        = 32'h0000_0100;
        cfg_we      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        test_bypass = 1'b0;
        perturb_on  = 1'b0;
        chk_random  = 1'b0;
        chk_pc_arm  = 1'b0;
        chk_no_irq  = 1'b0;
        chk_prio    = 1'b0;
        core_en     = 1'b0;
        ack_extra   = 0;
        lfsr_state  = 32'h2b8ad9c2;
        errors      = 0;
        pass_count  = 0;
        fail_count  = 0;
        test_name   = "reset";

        k = 0;
        while (!rst_n && k < 10)
        begin
            cycle();
            k++;
        end
        if (!rst_n)
            report_error("reset was never released");
        cycle();

        run_bypass();

        // Perturb mode hands the ack to the core model
        core_en    = 1'b1;
        perturb_on = 1'b1;
        write_cfg(0, FIELD_GLOBAL, 32'h1);

        run_random();
        run_pc_trigger();
        run_hold();
        run_priority();
        repeat (3) cycle();

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (errors == 0 && fail_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    // 40 ns period
    initial
    begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Reset held low for two rising edges, released off the edge
    initial
    begin
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        #5 rst_no = 1'b1;
    end

endmodule

/* irq_perturb_top.sv */
`timescale 1ns/1ps

module irq_perturb_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       irq_i,
    input  irq_perturb_pkg::irq_id_t   irq_id_i,
    input  logic                       irq_ack_i,
    input  irq_perturb_pkg::pc_t       pc_i,
    input  logic                       cfg_we_i,
    input  irq_perturb_pkg::cfg_addr_t cfg_addr_i,
    input  irq_perturb_pkg::cfg_data_t cfg_wdata_i,
    output logic                       irq_o,
    output irq_perturb_pkg::irq_id_t   irq_id_o,
    output logic                       irq_ack_o,
    output irq_perturb_pkg::irq_id_t   irq_act_id_o,
    output logic                       irq_id_we_o
);

    import irq_perturb_pkg::*;

    // Config to lanes
    logic                 perturb;
    logic [NUM_LANES-1:0] rearm;
    lane_mode_e           mode    [NUM_LANES];
    cycles_t              min_cyc [NUM_LANES];
    cycles_t              max_cyc [NUM_LANES];
    irq_id_t              min_id  [NUM_LANES];
    irq_id_t              max_id  [NUM_LANES];
    pc_t                  pc_trig [NUM_LANES];

    // Lanes to arbiter
    logic [NUM_LANES-1:0] lane_req;
    logic [NUM_LANES-1:0] lane_ack;
    irq_id_t              lane_id [NUM_LANES];

    // Arbiter core side
    logic                 arb_irq;
    irq_id_t              arb_id;
    logic                 arb_ack;

    irq_perturb_cfg u_cfg (
        .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
        .perturb_o(perturb), .rearm_o(rearm), .mode_o(mode),
        .min_cyc_o(min_cyc), .max_cyc_o(max_cyc),
        .min_id_o(min_id), .max_id_o(max_id), .pc_trig_o(pc_trig)
    );

    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        irq_lane #(.LANE_IDX(i)) u_lane (
            .clk_i, .rst_ni, .rearm_i(rearm[i]), .mode_i(mode[i]),
            .min_cyc_i(min_cyc[i]), .max_cyc_i(max_cyc[i]),
            .min_id_i(min_id[i]), .max_id_i(max_id[i]),
            .pc_trig_i(pc_trig[i]), .pc_i, .ack_i(lane_ack[i]),
            .req_o(lane_req[i]), .id_o(lane_id[i])
        );
    end

    // Core ack reaches the arbiter only in perturb mode
    assign arb_ack = perturb && irq_ack_i;

    irq_arbiter u_arb (
        .clk_i, .rst_ni, .req_i(lane_req), .id_i(lane_id), .irq_ack_i(arb_ack),
        .ack_o(lane_ack), .irq_o(arb_irq), .irq_id_o(arb_id),
        .irq_act_id_o, .irq_id_we_o
    );

    // Bypass passes the platform straight through
    assign irq_o     = perturb ? arb_irq : irq_i;
    assign irq_id_o  = perturb ? arb_id  : irq_id_i;
    assign irq_ack_o = perturb ? 1'b0    : irq_ack_i;

endmodule

/* irq_arbiter.sv */
`timescale 1ns/1ps

module irq_arbiter (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic [irq_perturb_pkg::NUM_LANES-1:0] req_i,
    input  irq_perturb_pkg::irq_id_t              id_i [irq_perturb_pkg::NUM_LANES],
    input  logic                                  irq_ack_i,
    output logic [irq_perturb_pkg::NUM_LANES-1:0] ack_o,
    output logic                                  irq_o,
    output irq_perturb_pkg::irq_id_t              irq_id_o,
    output irq_perturb_pkg::irq_id_t              irq_act_id_o,
    output logic                                  irq_id_we_o
);

    import irq_perturb_pkg::*;

    // Open grant and the lane it belongs to
    logic                 grant_q;
    lane_idx_t            sel_q;
    irq_id_t              irq_id_q;
    logic [NUM_LANES-1:0] ack_q;
    logic                 we_q;
    irq_id_t              act_id_q;

    // Lowest pending lane
    logic                 pend_any;
    lane_idx_t            pend_idx;
    logic                 start_grant;
    logic                 take_ack;

    //////////////////////////////////////////////////
    // Fixed priority with lane 0 first
    //////////////////////////////////////////////////

    always_comb
    begin
        pend_any = 1'b0;
        pend_idx = '0;
        // Walk down so the lowest index wins
        for (int l = NUM_LANES - 1; l >= 0; l--)
        begin
            if (req_i[l])
            begin
                pend_any = 1'b1;
                pend_idx = lane_idx_t'(l);
            end
        end
    end

    // Acked lane still shows req during the ack cycle
    assign start_grant = !grant_q && (ack_q == '0) && pend_any;
    assign take_ack    = grant_q && irq_ack_i;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            grant_q <= 1'b0;
            sel_q   <= '0;
            ack_q   <= '0;
            we_q    <= 1'b0;
        end
        else
        begin
            ack_q <= '0;
            we_q  <= 1'b0;
            if (start_grant)
            begin
                grant_q <= 1'b1;
                sel_q   <= pend_idx;
            end
            else if (take_ack)
            begin
                // Close the grant and pulse ack with the ID report
                grant_q      <= 1'b0;
                ack_q[sel_q] <= 1'b1;
                we_q         <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (start_grant)
            irq_id_q <= id_i[pend_idx];
        if (take_ack)
            act_id_q <= irq_id_q;
    end

    assign irq_o        = grant_q;
    assign irq_id_o     = irq_id_q;
    assign ack_o        = ack_q;
    assign irq_act_id_o = act_id_q;
    assign irq_id_we_o  = we_q;

    // Acked lane still holds its request in the ack cycle
    a_ack_on_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (ack_o != '0) |-> ((ack_o & req_i) == ack_o));

    // Granted lane keeps requesting while the core request is up
    a_grant_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
        irq_o |-> req_i[sel_q]);

endmodule

/* irq_lane.sv */
`timescale 1ns/1ps

module irq_lane #(
    parameter int LANE_IDX = 0
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        rearm_i,
    input  irq_perturb_pkg::lane_mode_e mode_i,
    input  irq_perturb_pkg::cycles_t    min_cyc_i,
    input  irq_perturb_pkg::cycles_t    max_cyc_i,
    input  irq_perturb_pkg::irq_id_t    min_id_i,
    input  irq_perturb_pkg::irq_id_t    max_id_i,
    input  irq_perturb_pkg::pc_t        pc_trig_i,
    input  irq_perturb_pkg::pc_t        pc_i,
    input  logic                        ack_i,
    output logic                        req_o,
    output irq_perturb_pkg::irq_id_t    id_o
);

    import irq_perturb_pkg::*;

    // Per-lane seed, never zero for the lane count in use
    localparam logic [LFSR_W-1:0] SEED = LFSR_SEED ^ {4{8'(LANE_IDX) * 8'h35}};

    lane_state_e       state_q, state_d;
    logic              req_q, req_d;
    logic [LFSR_W-1:0] lfsr_q;
    logic              lfsr_fb;
    cycles_t           cnt_q, cnt_d;
    irq_id_t           id_q, id_d;

    // Range reduction
    logic [CYCLES_W:0] span_cyc;
    logic [CYCLES_W:0] cyc_off;
    cycles_t           span_id;
    cycles_t           id_off;
    cycles_t           new_delay;
    irq_id_t           new_id;

    //////////////////////////////////////////////////
    // Free-running Fibonacci LFSR
    //////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    assign lfsr_fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];

    // Delay from low half, ID from high half
    always_comb
    begin
        if (max_cyc_i < min_cyc_i)
            span_cyc = (CYCLES_W+1)'(1);
        else
            span_cyc = {1'b0, max_cyc_i} - {1'b0, min_cyc_i} + (CYCLES_W+1)'(1);

        if (max_id_i < min_id_i)
            span_id = cycles_t'(1);
        else
            span_id = cycles_t'(max_id_i) - cycles_t'(min_id_i) + cycles_t'(1);

        cyc_off   = {1'b0, lfsr_q[CYCLES_W-1:0]} % span_cyc;
        id_off    = lfsr_q[LFSR_W-1 -: CYCLES_W] % span_id;
        new_delay = min_cyc_i + cyc_off[CYCLES_W-1:0];
        new_id    = min_id_i + id_off[IRQ_ID_W-1:0];
    end

    //////////////////////////////////////////////////
    // Lane FSM
    //////////////////////////////////////////////////

    always_comb
    begin
        state_d = state_q;
        req_d   = req_q;
        cnt_d   = cnt_q;
        id_d    = id_q;

        if (rearm_i)
        begin
            // New mode, start over
            state_d = ST_IDLE;
            req_d   = 1'b0;
        end
        else
        begin
            unique case (state_q)
                ST_IDLE:
                begin
                    if (mode_i == LANE_RANDOM)
                    begin
                        cnt_d   = new_delay;
                        id_d    = new_id;
                        state_d = ST_COUNT;
                    end
                    else if (mode_i == LANE_PC_TRIG && pc_i == pc_trig_i)
                    begin
                        // PC hit, request with the low ID
                        id_d    = min_id_i;
                        req_d   = 1'b1;
                        state_d = ST_REQ;
                    end
                end
                ST_COUNT:
                begin
                    if (cnt_q <= cycles_t'(1))
                    begin
                        req_d   = 1'b1;
                        state_d = ST_REQ;
                    end
                    else
                    begin
                        cnt_d = cnt_q - cycles_t'(1);
                    end
                end
                ST_REQ:
                begin
                    // Request and ID held until the arbiter acks
                    if (ack_i)
                    begin
                        req_d = 1'b0;
                        if (mode_i == LANE_RANDOM)
                        begin
                            cnt_d   = max_cyc_i;
                            state_d = ST_COOL;
                        end
                        else
                        begin
                            state_d = ST_DONE;
                        end
                    end
                end
                ST_COOL:
                begin
                    if (cnt_q <= cycles_t'(1))
                        state_d = ST_IDLE;
                    else
                        cnt_d = cnt_q - cycles_t'(1);
                end
                // PC trigger fired once, wait for rearm
                ST_DONE: ;
                default: state_d = ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q <= ST_IDLE;
            req_q   <= 1'b0;
            lfsr_q  <= SEED;
        end
        else
        begin
            state_q <= state_d;
            req_q   <= req_d;
            lfsr_q  <= {lfsr_q[LFSR_W-2:0], lfsr_fb};
        end
    end

    always_ff @(posedge clk_i)
    begin
        cnt_q <= cnt_d;
        id_q  <= id_d;
    end

    assign req_o = req_q;
    assign id_o  = id_q;

    // Request stays up with a steady ID until acked or rearmed
    a_req_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (req_o && !ack_i && !rearm_i) |=> (req_o && $stable(id_o)));

    // Random IDs land inside the configured window
    a_id_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (req_o && mode_i == LANE_RANDOM && min_id_i <= max_id_i)
        |-> (id_o >= min_id_i && id_o <= max_id_i));

endmodule

/* irq_perturb_cfg.sv */
`timescale 1ns/1ps

module irq_perturb_cfg (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 cfg_we_i,
    input  irq_perturb_pkg::cfg_addr_t           cfg_addr_i,
    input  irq_perturb_pkg::cfg_data_t           cfg_wdata_i,
    output logic                                 perturb_o,
    output logic [irq_perturb_pkg::NUM_LANES-1:0] rearm_o,
    output irq_perturb_pkg::lane_mode_e          mode_o    [irq_perturb_pkg::NUM_LANES],
    output irq_perturb_pkg::cycles_t             min_cyc_o [irq_perturb_pkg::NUM_LANES],
    output irq_perturb_pkg::cycles_t             max_cyc_o [irq_perturb_pkg::NUM_LANES],
    output irq_perturb_pkg::irq_id_t             min_id_o  [irq_perturb_pkg::NUM_LANES],
    output irq_perturb_pkg::irq_id_t             max_id_o  [irq_perturb_pkg::NUM_LANES],
    output irq_perturb_pkg::pc_t                 pc_trig_o [irq_perturb_pkg::NUM_LANES]
);

    import irq_perturb_pkg::*;

    // Address split into lane and field
    lane_idx_t  lane_sel;
    field_t     field_sel;

    // Register bank
    logic       perturb_q;
    lane_mode_e mode_q    [NUM_LANES];
    cycles_t    min_cyc_q [NUM_LANES];
    cycles_t    max_cyc_q [NUM_LANES];
    irq_id_t    min_id_q  [NUM_LANES];
    irq_id_t    max_id_q  [NUM_LANES];
    pc_t        pc_trig_q [NUM_LANES];

    assign lane_sel  = cfg_addr_i[CFG_ADDR_W-1 -: LANE_W];
    assign field_sel = cfg_addr_i[FIELD_W-1:0];

    //////////////////////////////////////////////////
    // Write decode
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            // Bypass with all lanes off
            perturb_q <= 1'b0;
            for (int l = 0; l < NUM_LANES; l++)
            begin
                mode_q[l]    <= LANE_OFF;
                min_cyc_q[l] <= '0;
                max_cyc_q[l] <= '0;
                min_id_q[l]  <= '0;
                max_id_q[l]  <= '0;
                pc_trig_q[l] <= '0;
            end
        end
        else if (cfg_we_i)
        begin
            unique case (field_sel)
                FIELD_MODE:    mode_q[lane_sel]    <= lane_mode_e'(cfg_wdata_i[1:0]);
                FIELD_MIN_CYC: min_cyc_q[lane_sel] <= cfg_wdata_i[CYCLES_W-1:0];
                FIELD_MAX_CYC: max_cyc_q[lane_sel] <= cfg_wdata_i[CYCLES_W-1:0];
                FIELD_MIN_ID:  min_id_q[lane_sel]  <= cfg_wdata_i[IRQ_ID_W-1:0];
                FIELD_MAX_ID:  max_id_q[lane_sel]  <= cfg_wdata_i[IRQ_ID_W-1:0];
                FIELD_PC_TRIG: pc_trig_q[lane_sel] <= cfg_wdata_i[PC_W-1:0];
                FIELD_GLOBAL:
                begin
                    // Global control lives on lane 0 only
                    if (lane_sel == '0)
                    begin
                        perturb_q <= cfg_wdata_i[0];
                    end
                end
                default: ;
            endcase
        end
    end

    // Mode write restarts the lane on the same edge
    always_comb
    begin
        for (int l = 0; l < NUM_LANES; l++)
        begin
            rearm_o[l] = cfg_we_i && (field_sel == FIELD_MODE) && (lane_sel == lane_idx_t'(l));
        end
    end

    assign perturb_o = perturb_q;
    assign mode_o    = mode_q;
    assign min_cyc_o = min_cyc_q;
    assign max_cyc_o = max_cyc_q;
    assign min_id_o  = min_id_q;
    assign max_id_o  = max_id_q;
    assign pc_trig_o = pc_trig_q;

    //////////////////////////////////////////////////
    // Range sanity after a max field write
    //////////////////////////////////////////////////

    for (genvar l = 0; l < NUM_LANES; l++)
    begin : g_range_chk
        // Software writes min first, then max
        a_cyc_order : assert property (@(posedge clk_i) disable iff (!rst_ni)
            (cfg_we_i && lane_sel == lane_idx_t'(l) && field_sel == FIELD_MAX_CYC)
            |=> (min_cyc_q[l] <= max_cyc_q[l]))
            else $warning("lane %0d delay range has min above max", l);

        a_id_order : assert property (@(posedge clk_i) disable iff (!rst_ni)
            (cfg_we_i && lane_sel == lane_idx_t'(l) && field_sel == FIELD_MAX_ID)
            |=> (min_id_q[l] <= max_id_q[l]))
            else $warning("lane %0d ID range has min above max", l);
    end

endmodule

/* irq_perturb_pkg.sv */
package irq_perturb_pkg;

    //////////////////////////////////////////////////
    // Widths and lane count
    //////////////////////////////////////////////////

    // Number of independent interrupt lanes
    localparam int NUM_LANES  = 4;
    // Lane select bits in the config address
    localparam int LANE_W     = 2;
    // Field select bits in the config address
    localparam int FIELD_W    = 3;
    localparam int CFG_ADDR_W = LANE_W + FIELD_W;
    localparam int CFG_DATA_W = 32;
    localparam int IRQ_ID_W   = 5;
    localparam int CYCLES_W   = 16;
    localparam int PC_W       = 32;
    localparam int LFSR_W     = 32;

    // Typed vectors
    typedef logic [IRQ_ID_W-1:0]   irq_id_t;
    typedef logic [CYCLES_W-1:0]   cycles_t;
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
    typedef logic [CFG_DATA_W-1:0] cfg_data_t;
    typedef logic [LANE_W-1:0]     lane_idx_t;
    typedef logic [FIELD_W-1:0]    field_t;

    // Lane operating mode, written through FIELD_MODE
    typedef enum logic [1:0] {
        LANE_OFF     = 2'd0,
        LANE_RANDOM  = 2'd1,
        LANE_PC_TRIG = 2'd2
    } lane_mode_e;

    // Lane FSM states
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_COUNT = 3'd1,
        ST_REQ   = 3'd2,
        ST_COOL  = 3'd3,
        ST_DONE  = 3'd4
    } lane_state_e;

    //////////////////////////////////////////////////
    // Config field codes, low bits of the address
    //////////////////////////////////////////////////

    localparam field_t FIELD_MODE    = 3'd0;
    localparam field_t FIELD_MIN_CYC = 3'd1;
    localparam field_t FIELD_MAX_CYC = 3'd2;
    localparam field_t FIELD_MIN_ID  = 3'd3;
    localparam field_t FIELD_MAX_ID  = 3'd4;
    localparam field_t FIELD_PC_TRIG = 3'd5;
    // Only decoded on lane 0, bit 0 selects perturb mode
    localparam field_t FIELD_GLOBAL  = 3'd6;

    // Base seed, every lane mixes in its own index
    localparam logic [LFSR_W-1:0] LFSR_SEED = 32'hACE1_2468;

endpackage
